/* cmd_defines.svh */
`ifndef CMD_DEFINES_SVH
`define CMD_DEFINES_SVH

// ==================================================
// host channel
// ==================================================
// width of one channel byte
`define CMD_BYTE_W 8

// token slots in the receive buffer, also the initial sender credit
`define CMD_BUF_DEPTH 4

// ==================================================
// display parameters
// ==================================================
// offsets with bit 7 set read back as this value
`define OFFSET_LIMIT 128

// payload bytes per multi-byte command
`define DISP_BYTES 2
`define GALVO_BYTES 3

`endif

/* cmd_token_pkg.sv */
`include "cmd_defines.svh"

package cmd_token_pkg;

    // one raw byte of the host channel
    typedef logic [`CMD_BYTE_W-1:0] cmd_byte_t;

    // ==================================================
    // instruction codes
    // ==================================================
    // configuration commands in 0x10..0x4f, control in 0x00..0x0f
    typedef enum logic [`CMD_BYTE_W-1:0] {
        OP_IDLE        = 8'h00,
        OP_ACK         = 8'h01,
        OP_OFFSET_H    = 8'h10,
        OP_OFFSET_V    = 8'h11,
        OP_DISPLAY_CYC = 8'h20,
        OP_START_SEQ   = 8'h30,
        OP_GALVO_X     = 8'h40,
        OP_GALVO_Y     = 8'h41
    } cmd_opcode_e;

    // a token is either an instruction or a data byte
    typedef struct packed {
        logic      is_instr;
        cmd_byte_t payload;
    } cmd_token_t;

endpackage

/* cmd_param_pkg.sv */
`include "cmd_defines.svh"

package cmd_param_pkg;
    import cmd_token_pkg::*;

    // ==================================================
    // parameter field types
    // ==================================================
    typedef logic [`CMD_BYTE_W-1:0]              offset_t;
    typedef logic [`CMD_BYTE_W*`DISP_BYTES-1:0]  disp_cycles_t;
    typedef logic [`CMD_BYTE_W*`GALVO_BYTES-1:0] galvo_t;

    // which parameter a write goes to
    typedef enum logic [2:0] {
        SEL_OFFSET_H,
        SEL_OFFSET_V,
        SEL_DISPLAY,
        SEL_GALVO_X,
        SEL_GALVO_Y
    } param_sel_e;

    // one byte write from the sequencer
    // sign set means data[0] goes to the sign bit of the selected offset
    typedef struct packed {
        logic       valid;
        param_sel_e sel;
        logic [1:0] idx;
        logic       sign;
        cmd_byte_t  data;
    } param_wr_t;

    // full set of display parameters as seen by the scan engine
    typedef struct packed {
        offset_t      offset_h;
        logic         sign_h;
        offset_t      offset_v;
        logic         sign_v;
        disp_cycles_t disp_cycles;
        galvo_t       galvo_x;
        galvo_t       galvo_y;
    } display_params_t;

endpackage

/* rx_token_buffer.sv */
`timescale 1ns/100ps
`include "cmd_defines.svh"

module rx_token_buffer
    import cmd_token_pkg::*;
(
    input  logic       iCLK,
    input  logic       iRST,
    input  cmd_token_t in_token,
    input  logic       in_valid,
    input  logic       pop,
    output cmd_token_t head,
    output logic       head_valid,
    output logic       credit_return
);

    localparam int PTR_W = $clog2(`CMD_BUF_DEPTH);

    cmd_token_t       mem [`CMD_BUF_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    logic             do_pop;

    // circular pointer advance, also correct for depths that are not a power of two
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(`CMD_BUF_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign do_pop     = pop && head_valid;
    assign head       = mem[rd_ptr];
    assign head_valid = (count != '0);

    // the sender's credit keeps occupancy within depth, so no full check here
    always_ff @(posedge iCLK) begin
        if (in_valid) begin
            mem[wr_ptr] <= in_token;
        end
    end

    always_ff @(posedge iCLK or posedge iRST) begin
        if (iRST) begin
            wr_ptr        <= '0;
            rd_ptr        <= '0;
            count         <= '0;
            credit_return <= 1'b0;
        end else begin
            if (in_valid) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({in_valid, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            // one credit back per token handed on
            credit_return <= do_pop;
        end
    end

endmodule

/* cmd_sequencer.sv */
`timescale 1ns/100ps
`include "cmd_defines.svh"

module cmd_sequencer
    import cmd_token_pkg::*;
    import cmd_param_pkg::*;
(
    input  logic       iCLK,
    input  logic       iRST,
    input  cmd_token_t head,
    input  logic       head_valid,
    output logic       pop,
    output param_wr_t  param_wr,
    output logic       seq_trigger,
    output logic       error
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_ERROR,
        ST_WAIT_ACK,
        ST_OFFSET_NUM,
        ST_OFFSET_SIGN,
        ST_DISPLAY_BYTE,
        ST_GALVO_BYTE
    } seq_state_e;

    seq_state_e  state;
    seq_state_e  state_next;
    seq_state_e  payload_exit;
    param_sel_e  sel_q;
    param_sel_e  sel_next;
    logic [1:0]  idx_q;
    logic [1:0]  idx_next;
    param_wr_t   wr_next;
    logic        trig_next;
    cmd_opcode_e opcode;
    logic        is_instr;
    logic        is_data;

    // every state takes the head, so the buffer never waits on us
    assign pop      = head_valid;
    assign opcode   = cmd_opcode_e'(head.payload);
    assign is_instr = head_valid && head.is_instr;
    assign is_data  = head_valid && !head.is_instr;
    assign error    = (state == ST_ERROR);

    // an instruction in the middle of a payload: IDLE aborts, anything else is a violation
    assign payload_exit = (opcode == OP_IDLE) ? ST_IDLE : ST_ERROR;

    // ==================================================
    // next state and write decode
    // ==================================================
    always_comb begin
        state_next   = state;
        sel_next     = sel_q;
        idx_next     = idx_q;
        trig_next    = 1'b0;
        wr_next      = '0;
        wr_next.sel  = sel_q;
        wr_next.idx  = idx_q;
        wr_next.data = head.payload;

        case (state)
            // data tokens fall through here and are dropped
            ST_IDLE, ST_ERROR: begin
                if (is_instr) begin
                    idx_next = '0;
                    case (opcode)
                        OP_IDLE, OP_ACK: state_next = ST_IDLE;
                        OP_OFFSET_H: begin
                            sel_next   = SEL_OFFSET_H;
                            state_next = ST_OFFSET_NUM;
                        end
                        OP_OFFSET_V: begin
                            sel_next   = SEL_OFFSET_V;
                            state_next = ST_OFFSET_NUM;
                        end
                        OP_DISPLAY_CYC: begin
                            sel_next   = SEL_DISPLAY;
                            state_next = ST_DISPLAY_BYTE;
                        end
                        OP_GALVO_X: begin
                            sel_next   = SEL_GALVO_X;
                            state_next = ST_GALVO_BYTE;
                        end
                        OP_GALVO_Y: begin
                            sel_next   = SEL_GALVO_Y;
                            state_next = ST_GALVO_BYTE;
                        end
                        OP_START_SEQ: begin
                            trig_next  = 1'b1;
                            state_next = ST_WAIT_ACK;
                        end
                        default: state_next = ST_ERROR;
                    endcase
                end
            end

            ST_WAIT_ACK: begin
                if (head_valid) begin
                    state_next = (is_instr && opcode == OP_ACK) ? ST_IDLE : ST_ERROR;
                end
            end

            ST_OFFSET_NUM: begin
                if (is_instr) begin
                    state_next = payload_exit;
                end else if (is_data) begin
                    wr_next.valid = 1'b1;
                    state_next    = ST_OFFSET_SIGN;
                end
            end

            ST_OFFSET_SIGN: begin
                if (is_instr) begin
                    state_next = payload_exit;
                end else if (is_data) begin
                    wr_next.valid = 1'b1;
                    wr_next.sign  = 1'b1;
                    state_next    = ST_WAIT_ACK;
                end
            end

            // bytes arrive low first
            ST_DISPLAY_BYTE: begin
                if (is_instr) begin
                    state_next = payload_exit;
                end else if (is_data) begin
                    wr_next.valid = 1'b1;
                    if (idx_q == 2'(`DISP_BYTES - 1)) begin
                        state_next = ST_WAIT_ACK;
                    end else begin
                        idx_next = idx_q + 1'b1;
                    end
                end
            end

            ST_GALVO_BYTE: begin
                if (is_instr) begin
                    state_next = payload_exit;
                end else if (is_data) begin
                    wr_next.valid = 1'b1;
                    if (idx_q == 2'(`GALVO_BYTES - 1)) begin
                        state_next = ST_WAIT_ACK;
                    end else begin
                        idx_next = idx_q + 1'b1;
                    end
                end
            end

            default: state_next = ST_IDLE;
        endcase
    end

    // write strobe and trigger leave one cycle after the token is taken
    always_ff @(posedge iCLK or posedge iRST) begin
        if (iRST) begin
            state       <= ST_IDLE;
            sel_q       <= SEL_OFFSET_H;
            idx_q       <= '0;
            param_wr    <= '0;
            seq_trigger <= 1'b0;
        end else begin
            state       <= state_next;
            sel_q       <= sel_next;
            idx_q       <= idx_next;
            param_wr    <= wr_next;
            seq_trigger <= trig_next;
        end
    end

endmodule

/* param_registers.sv */
`timescale 1ns/100ps
`include "cmd_defines.svh"

module param_registers
    import cmd_param_pkg::*;
(
    input  logic            iCLK,
    input  logic            iRST,
    input  param_wr_t       param_wr,
    output display_params_t params
);

    offset_t      off_h;
    offset_t      off_v;
    logic         sgn_h;
    logic         sgn_v;
    disp_cycles_t disp;
    galvo_t       galvo_x;
    galvo_t       galvo_y;

    // magnitudes with the top bit set saturate at the limit
    function automatic offset_t clamp_offset(input offset_t v);
        return v[$bits(offset_t)-1] ? offset_t'(`OFFSET_LIMIT) : v;
    endfunction

    // ==================================================
    // byte-wise register writes
    // ==================================================
    always_ff @(posedge iCLK or posedge iRST) begin
        if (iRST) begin
            off_h   <= '0;
            off_v   <= '0;
            sgn_h   <= 1'b0;
            sgn_v   <= 1'b0;
            disp    <= '0;
            galvo_x <= '0;
            galvo_y <= '0;
        end else if (param_wr.valid) begin
            case (param_wr.sel)
                SEL_OFFSET_H: begin
                    if (param_wr.sign) begin
                        sgn_h <= param_wr.data[0];
                    end else begin
                        off_h <= param_wr.data;
                    end
                end
                SEL_OFFSET_V: begin
                    if (param_wr.sign) begin
                        sgn_v <= param_wr.data[0];
                    end else begin
                        off_v <= param_wr.data;
                    end
                end
                SEL_DISPLAY: disp[param_wr.idx*`CMD_BYTE_W +: `CMD_BYTE_W] <= param_wr.data;
                SEL_GALVO_X: galvo_x[param_wr.idx*`CMD_BYTE_W +: `CMD_BYTE_W] <= param_wr.data;
                SEL_GALVO_Y: galvo_y[param_wr.idx*`CMD_BYTE_W +: `CMD_BYTE_W] <= param_wr.data;
                default: ;
            endcase
        end
    end

    always_comb begin
        params.offset_h    = clamp_offset(off_h);
        params.sign_h      = sgn_h;
        params.offset_v    = clamp_offset(off_v);
        params.sign_v      = sgn_v;
        params.disp_cycles = disp;
        params.galvo_x     = galvo_x;
        params.galvo_y     = galvo_y;
    end

endmodule

/* cmd_decoder_top.sv */
`timescale 1ns/100ps

module cmd_decoder_top
    import cmd_token_pkg::*;
    import cmd_param_pkg::*;
(
    input  logic            iCLK,
    input  logic            iRST,
    input  cmd_token_t      in_token,
    input  logic            in_valid,
    output logic            credit_return,
    output display_params_t params,
    output logic            seq_trigger,
    output logic            error
);

    cmd_token_t head;
    logic       head_valid;
    logic       pop;
    param_wr_t  param_wr;

    // token buffer, returns host credits
    rx_token_buffer u_buffer (
        .iCLK          (iCLK),
        .iRST          (iRST),
        .in_token      (in_token),
        .in_valid      (in_valid),
        .pop           (pop),
        .head          (head),
        .head_valid    (head_valid),
        .credit_return (credit_return)
    );

    cmd_sequencer u_sequencer (
        .iCLK        (iCLK),
        .iRST        (iRST),
        .head        (head),
        .head_valid  (head_valid),
        .pop         (pop),
        .param_wr    (param_wr),
        .seq_trigger (seq_trigger),
        .error       (error)
    );

    param_registers u_registers (
        .iCLK     (iCLK),
        .iRST     (iRST),
        .param_wr (param_wr),
        .params   (params)
    );

endmodule

/* tb_cmd_decoder.sv */
`timescale 1ns/100ps
`include "cmd_defines.svh"

module tb_cmd_decoder
    import cmd_token_pkg::*;
    import cmd_param_pkg::*;
();

    // tokens sent over all tests below
    localparam int TOTAL_TOKENS   = 132;
    localparam int TIMEOUT_CYCLES = 20 * TOTAL_TOKENS + 100;

    typedef enum {
        M_IDLE,
        M_ERROR,
        M_WAIT_ACK,
        M_OFF_NUM,
        M_OFF_SIGN,
        M_DISP,
        M_GALVO
    } model_state_e;

    logic            iCLK;
    logic            iRST;
    cmd_token_t      in_token;
    logic            in_valid;
    logic            credit_return;
    display_params_t params;
    logic            seq_trigger;
    logic            error;

    int          sent_count  = 0;
    int          ret_count   = 0;
    int          trig_count  = 0;
    int          cycle_count = 0;
    logic [15:0] lfsr        = 16'd54;

    // reference model
    display_params_t m_params     = '0;
    model_state_e    m_state      = M_IDLE;
    param_sel_e      m_sel        = SEL_OFFSET_H;
    int              m_idx        = 0;
    int              m_trig_count = 0;

    cmd_decoder_top dut (
        .iCLK          (iCLK),
        .iRST          (iRST),
        .in_token      (in_token),
        .in_valid      (in_valid),
        .credit_return (credit_return),
        .params        (params),
        .seq_trigger   (seq_trigger),
        .error         (error)
    );

    always #50 iCLK = ~iCLK;

    // credit and trigger pulses counted on the rising edge
    always @(posedge iCLK) begin
        cycle_count++;
        if (credit_return) begin
            ret_count++;
        end
        if (seq_trigger) begin
            trig_count++;
        end
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            abort_run();
        end
    end

    task automatic abort_run();
        $display("Finished with errors");
        $fatal(1, "stopped at the first failure");
    endtask

    // ==================================================
    // random source and reference model
    // ==================================================
    // Galois LFSR with polynomial x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic lfsr_bit();
        logic b;
        b = lfsr[0];
        lfsr = lfsr >> 1;
        if (b) begin
            lfsr = lfsr ^ 16'hB400;
        end
        return b;
    endfunction

    function automatic cmd_byte_t rand_bits(input int n);
        cmd_byte_t v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[6:0], lfsr_bit()};
        end
        return v;
    endfunction

    // upper half of k gives codes that no command uses
    function automatic cmd_byte_t pick_opcode(input cmd_byte_t k);
        if (k[3]) begin
            return {5'b01010, k[2:0]};
        end
        case (k[2:0])
            3'd0: return OP_IDLE;
            3'd1: return OP_ACK;
            3'd2: return OP_OFFSET_H;
            3'd3: return OP_OFFSET_V;
            3'd4: return OP_DISPLAY_CYC;
            3'd5: return OP_START_SEQ;
            3'd6: return OP_GALVO_X;
            default: return OP_GALVO_Y;
        endcase
    endfunction

    function automatic void model_write(input param_sel_e sel, input int idx,
                                        input cmd_byte_t data, input logic sign);
        case (sel)
            SEL_OFFSET_H: begin
                if (sign) begin
                    m_params.sign_h = data[0];
                end else begin
                    m_params.offset_h = data;
                end
            end
            SEL_OFFSET_V: begin
                if (sign) begin
                    m_params.sign_v = data[0];
                end else begin
                    m_params.offset_v = data;
                end
            end
            SEL_DISPLAY: m_params.disp_cycles[idx*`CMD_BYTE_W +: `CMD_BYTE_W] = data;
            SEL_GALVO_X: m_params.galvo_x[idx*`CMD_BYTE_W +: `CMD_BYTE_W] = data;
            default:     m_params.galvo_y[idx*`CMD_BYTE_W +: `CMD_BYTE_W] = data;
        endcase
    endfunction

    function automatic void model_step(input cmd_token_t tok);
        // an instruction inside a payload aborts on IDLE and is a violation otherwise
        if (tok.is_instr && m_state inside {M_OFF_NUM, M_OFF_SIGN, M_DISP, M_GALVO}) begin
            m_state = (tok.payload == OP_IDLE) ? M_IDLE : M_ERROR;
            return;
        end
        case (m_state)
            M_IDLE, M_ERROR: begin
                if (tok.is_instr) begin
                    m_idx = 0;
                    case (tok.payload)
                        OP_IDLE, OP_ACK: m_state = M_IDLE;
                        OP_OFFSET_H: begin
                            m_sel   = SEL_OFFSET_H;
                            m_state = M_OFF_NUM;
                        end
                        OP_OFFSET_V: begin
                            m_sel   = SEL_OFFSET_V;
                            m_state = M_OFF_NUM;
                        end
                        OP_DISPLAY_CYC: begin
                            m_sel   = SEL_DISPLAY;
                            m_state = M_DISP;
                        end
                        OP_GALVO_X: begin
                            m_sel   = SEL_GALVO_X;
                            m_state = M_GALVO;
                        end
                        OP_GALVO_Y: begin
                            m_sel   = SEL_GALVO_Y;
                            m_state = M_GALVO;
                        end
                        OP_START_SEQ: begin
                            m_trig_count++;
                            m_state = M_WAIT_ACK;
                        end
                        default: m_state = M_ERROR;
                    endcase
                end
            end
            M_OFF_NUM: begin
                model_write(m_sel, 0, tok.payload, 1'b0);
                m_state = M_OFF_SIGN;
            end
            M_OFF_SIGN: begin
                model_write(m_sel, 0, tok.payload, 1'b1);
                m_state = M_WAIT_ACK;
            end
            M_DISP, M_GALVO: begin
                model_write(m_sel, m_idx, tok.payload, 1'b0);
                m_idx++;
                if (m_idx == ((m_state == M_DISP) ? `DISP_BYTES : `GALVO_BYTES)) begin
                    m_state = M_WAIT_ACK;
                end
            end
            default: m_state = (tok.is_instr && tok.payload == OP_ACK) ? M_IDLE : M_ERROR;
        endcase
    endfunction

    // offsets with bit 7 set read back saturated
    function automatic display_params_t expected_view();
        display_params_t p;
        p = m_params;
        if (p.offset_h[7]) begin
            p.offset_h = offset_t'(`OFFSET_LIMIT);
        end
        if (p.offset_v[7]) begin
            p.offset_v = offset_t'(`OFFSET_LIMIT);
        end
        return p;
    endfunction

    // ==================================================
    // compare tasks
    // ==================================================
    task automatic check_params(input string name, input display_params_t exp,
                                input display_params_t act);
        if (exp !== act) begin
            $display("MISMATCH %s params: expected %h actual %h", name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            $display("MISMATCH %s error flag: expected %b actual %b", name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (exp != act) begin
            $display("MISMATCH %s count: expected %0d actual %0d", name, exp, act);
            abort_run();
        end
    endtask

    // ==================================================
    // stimulus on the falling edge
    // ==================================================
    task automatic send_token(input cmd_token_t tok);
        // hold while every credit is in flight
        while (sent_count - ret_count >= `CMD_BUF_DEPTH) begin
            @(negedge iCLK);
        end
        model_step(tok);
        in_token = tok;
        in_valid = 1'b1;
        sent_count++;
        @(negedge iCLK);
        in_valid = 1'b0;
    endtask

    task automatic send_instr(input cmd_byte_t op);
        send_token({1'b1, op});
    endtask

    task automatic send_data(input cmd_byte_t d);
        send_token({1'b0, d});
    endtask

    task automatic send_payload(input cmd_byte_t op, input int n);
        send_instr(op);
        repeat (n) begin
            send_data(rand_bits(8));
        end
    endtask

    task automatic send_command(input cmd_byte_t op, input int n);
        send_payload(op, n);
        send_instr(OP_ACK);
    endtask

    // magnitude, sign and ACK, with the magnitude pushed past the limit on request
    task automatic send_offset(input cmd_byte_t op, input logic saturate);
        cmd_byte_t mag;
        mag = rand_bits(8);
        if (saturate) begin
            mag[7] = 1'b1;
        end
        send_instr(op);
        send_data(mag);
        send_data(rand_bits(8));
        send_instr(OP_ACK);
    endtask

    // outputs are final two cycles after the last credit comes back
    task automatic settle_and_compare(input string name);
        while (ret_count < sent_count) begin
            @(negedge iCLK);
        end
        repeat (2) @(negedge iCLK);
        check_params(name, expected_view(), params);
        check_flag(name, m_state == M_ERROR, error);
        check_count({name, " triggers"}, m_trig_count, trig_count);
        check_count({name, " credits"}, sent_count, ret_count);
    endtask

    initial begin
        cmd_byte_t k;
        iCLK     = 1'b0;
        iRST     = 1'b1;
        in_valid = 1'b0;
        in_token = '0;
        repeat (4) @(negedge iCLK);
        iRST = 1'b0;
        settle_and_compare("reset");

        // offsets with the first magnitudes forced above the limit
        for (int i = 0; i < 4; i++) begin
            send_offset(OP_OFFSET_H, i == 0);
            settle_and_compare("offset_h");
            send_offset(OP_OFFSET_V, i == 0);
            settle_and_compare("offset_v");
        end

        for (int i = 0; i < 2; i++) begin
            send_command(OP_DISPLAY_CYC, `DISP_BYTES);
            settle_and_compare("display");
            send_command(OP_GALVO_X, `GALVO_BYTES);
            settle_and_compare("galvo_x");
            send_command(OP_GALVO_Y, `GALVO_BYTES);
            settle_and_compare("galvo_y");
        end

        for (int i = 0; i < 2; i++) begin
            send_command(OP_START_SEQ, 0);
            settle_and_compare("start_seq");
        end

        // protocol violations and recovery
        send_payload(OP_OFFSET_H, 3);
        settle_and_compare("missing_ack");
        check_flag("missing_ack", 1'b1, error);
        send_command(OP_DISPLAY_CYC, `DISP_BYTES);
        settle_and_compare("recover_ack");
        send_instr(8'h7e);
        settle_and_compare("bad_opcode");
        check_flag("bad_opcode", 1'b1, error);
        send_command(OP_GALVO_X, `GALVO_BYTES);
        settle_and_compare("recover_opcode");
        send_payload(OP_GALVO_Y, 1);
        send_instr(OP_OFFSET_V);
        settle_and_compare("nested_instr");
        check_flag("nested_instr", 1'b1, error);
        send_command(OP_OFFSET_V, 2);
        settle_and_compare("recover_nested");

        // abort keeps the bytes written so far
        send_payload(OP_GALVO_X, 2);
        send_instr(OP_IDLE);
        settle_and_compare("idle_abort");
        check_flag("idle_abort", 1'b0, error);
        repeat (3) begin
            send_data(rand_bits(8));
        end
        settle_and_compare("stray_data");

        // random burst at full credit
        for (int i = 0; i < 40; i++) begin
            if (lfsr_bit()) begin
                k = rand_bits(4);
                send_instr(pick_opcode(k));
            end else begin
                send_data(rand_bits(8));
            end
        end
        settle_and_compare("burst");

        $display("Finished with no errors");
        $finish;
    end

endmodule

/* verilog.f */
+incdir+.
cmd_token_pkg.sv
cmd_param_pkg.sv
rx_token_buffer.sv
cmd_sequencer.sv
param_registers.sv
cmd_decoder_top.sv
tb_cmd_decoder.sv

/* run_sim.sh */
#!/bin/sh
# build and run the command decoder testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f verilog.f --top-module tb_cmd_decoder
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/Vtb_cmd_decoder)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
fi

if printf '%s\n' "$output" | grep -qx "Finished with no errors"; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1
